//--- compile.f
+incdir+sim
hw/fifo_buffer_pkg.sv
hw/sync_dual_port_ram.sv
hw/fifo_ctrl.sv
hw/ram_write_arbiter.sv
hw/apb_fifo_regs.sv
hw/fifo_buffer_top.sv
sim/tb_fifo_buffer.sv

//--- hw/apb_fifo_regs.sv
// APB slave for the two data registers and the status register
// writes push through the write arbiter, reads pop and wait one cycle for the ram
`timescale 1ns/1ps

module apb_fifo_regs
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  fifo_buffer_pkg::apb_addr_t paddr,
  input  fifo_buffer_pkg::apb_data_t pwdata,
  output fifo_buffer_pkg::apb_data_t prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       apb_push_req,
  output logic                       apb_push_ch,
  output fifo_buffer_pkg::data_t     apb_push_data,
  input  logic                       apb_push_gnt,
  output logic                       pop0,
  output logic                       pop1,
  output fifo_buffer_pkg::ram_addr_t ram_raddr,
  input  fifo_buffer_pkg::data_t     ram_rdata,
  input  fifo_buffer_pkg::ptr_t      rd_ptr0,
  input  fifo_buffer_pkg::ptr_t      rd_ptr1,
  input  logic                       full0,
  input  logic                       empty0,
  input  logic                       full1,
  input  logic                       empty1,
  input  fifo_buffer_pkg::count_t    count0,
  input  fifo_buffer_pkg::count_t    count1
);

  import fifo_buffer_pkg::*;

  apb_state_t state;
  apb_state_t next_state;
  logic       is_data;      // paddr hits DATA0 or DATA1
  logic       is_status;
  logic       sel_ch;       // channel picked by the data address
  logic       sel_full;
  logic       sel_empty;
  apb_data_t  status_word;

  // address decode
  assign is_data   = (paddr == REG_DATA0) || (paddr == REG_DATA1);
  assign is_status = (paddr == REG_STATUS);
  assign sel_ch    = (paddr == REG_DATA1);
  assign sel_full  = sel_ch ? full1 : full0;
  assign sel_empty = sel_ch ? empty1 : empty0;

  // push side of the arbiter, only the low byte of pwdata is stored
  assign apb_push_ch   = sel_ch;
  assign apb_push_data = pwdata[DATA_W-1:0];

  // read address follows the selected channel's read pointer
  assign ram_raddr = {sel_ch, sel_ch ? rd_ptr1 : rd_ptr0};

  // status word
  always_comb
  begin
    status_word                            = '0;
    status_word[ST_EMPTY0]                 = empty0;
    status_word[ST_FULL0]                  = full0;
    status_word[ST_EMPTY1]                 = empty1;
    status_word[ST_FULL1]                  = full1;
    status_word[ST_COUNT0 +: PTR_W + 1]    = count0;
    status_word[ST_COUNT1 +: PTR_W + 1]    = count1;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  // decode, guards and handshake, all combinational on the current state
  always_comb
  begin
    next_state   = state;
    pready       = 1'b0;
    pslverr      = 1'b0;
    prdata       = '0;   // zero unless a read returns data
    apb_push_req = 1'b0;
    pop0         = 1'b0;
    pop1         = 1'b0;
    case (state)
      IDLE:
      begin
        if (psel && !penable)
        begin
          next_state = ACCESS;  // setup phase, access starts next cycle
        end
      end
      ACCESS:
      begin
        if (is_data && pwrite)
        begin
          if (sel_full)
          begin
            pready  = 1'b1;  // overflow, byte dropped
            pslverr = 1'b1;
          end
          else
          begin
            apb_push_req = 1'b1;
            pready       = apb_push_gnt;  // stalls while the stream holds the port
          end
        end
        else if (is_data)
        begin
          if (sel_empty)
          begin
            pready  = 1'b1;  // underflow
            pslverr = 1'b1;
          end
          else
          begin
            pop0       = ~sel_ch;
            pop1       = sel_ch;
            next_state = READ_WAIT;  // ram samples ram_raddr at this edge
          end
        end
        else if (is_status && !pwrite)
        begin
          pready = 1'b1;
          prdata = status_word;
        end
        else
        begin
          pready  = 1'b1;  // unknown address or status write
          pslverr = 1'b1;
        end
        if (pready)
        begin
          next_state = IDLE;
        end
      end
      READ_WAIT:
      begin
        pready     = 1'b1;
        prdata     = apb_data_t'(ram_rdata);  // registered ram output, zero extended
        next_state = IDLE;
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

//--- hw/fifo_buffer_pkg.sv
// shared widths, register map and types for the two-channel APB byte buffer
// every RTL module imports this, and so does the testbench reference model
package fifo_buffer_pkg;

  localparam int DATA_W     = 8;               // bits per stored byte
  localparam int PTR_W      = 4;               // 16 entries per channel
  localparam int NUM_CH     = 2;               // channel 0 is APB only, channel 1 also takes the stream
  localparam int CH_W       = $clog2(NUM_CH);  // channel field of the ram address
  localparam int RAM_ADDR_W = PTR_W + CH_W;    // {channel, pointer}, channel on top

  typedef logic [DATA_W-1:0]     data_t;       // one stored byte
  typedef logic [PTR_W-1:0]      ptr_t;        // write or read pointer inside a channel
  typedef logic [PTR_W:0]        count_t;      // fill level 0..16
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [7:0]            apb_addr_t;
  typedef logic [31:0]           apb_data_t;

  // register offsets
  localparam apb_addr_t REG_DATA0  = 8'h00;    // push on write, pop on read, channel 0
  localparam apb_addr_t REG_DATA1  = 8'h04;    // same for channel 1
  localparam apb_addr_t REG_STATUS = 8'h08;    // read only

  // status word layout, unused bits read as zero
  localparam int ST_EMPTY0 = 0;
  localparam int ST_FULL0  = 1;
  localparam int ST_EMPTY1 = 2;
  localparam int ST_FULL1  = 3;
  localparam int ST_COUNT0 = 8;                // count0 in 12:8
  localparam int ST_COUNT1 = 16;               // count1 in 20:16

  // APB slave states
  typedef enum logic [1:0]
  {
    IDLE,       // waiting for a setup phase
    ACCESS,     // first and later access cycles
    READ_WAIT   // one wait state for the registered ram output
  } apb_state_t;

endpackage

//--- hw/fifo_buffer_top.sv
// top of the two-channel byte buffer, APB host port plus a byte stream into channel 1
// connects the APB slave, write arbiter, both pointer controllers and the shared ram
`timescale 1ns/1ps

module fifo_buffer_top
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  fifo_buffer_pkg::apb_addr_t paddr,
  input  fifo_buffer_pkg::apb_data_t pwdata,
  output fifo_buffer_pkg::apb_data_t prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  logic                       in_valid,
  input  fifo_buffer_pkg::data_t     in_data,
  output logic                       in_ready
);

  import fifo_buffer_pkg::*;

  // APB slave to arbiter
  logic      apb_push_req;
  logic      apb_push_ch;
  data_t     apb_push_data;
  logic      apb_push_gnt;

  // ram ports
  logic      ram_we;
  ram_addr_t ram_waddr;
  data_t     ram_wdata;
  ram_addr_t ram_raddr;
  data_t     ram_rdata;

  // per channel pointer state
  logic      push0, push1;
  logic      pop0, pop1;
  ptr_t      wr_ptr0, wr_ptr1;
  ptr_t      rd_ptr0, rd_ptr1;
  logic      full0, full1;
  logic      empty0, empty1;
  count_t    count0, count1;

  apb_fifo_regs u_apb_fifo_regs
  (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .apb_push_req(apb_push_req), .apb_push_ch(apb_push_ch),
    .apb_push_data(apb_push_data), .apb_push_gnt(apb_push_gnt),
    .pop0(pop0), .pop1(pop1),
    .ram_raddr(ram_raddr), .ram_rdata(ram_rdata),
    .rd_ptr0(rd_ptr0), .rd_ptr1(rd_ptr1),
    .full0(full0), .empty0(empty0), .full1(full1), .empty1(empty1),
    .count0(count0), .count1(count1)
  );

  ram_write_arbiter u_ram_write_arbiter
  (
    .clk(clk), .reset(reset),
    .apb_push_req(apb_push_req), .apb_push_ch(apb_push_ch),
    .apb_push_data(apb_push_data), .apb_push_gnt(apb_push_gnt),
    .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
    .full1(full1),
    .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
    .push0(push0), .push1(push1),
    .wr_ptr0(wr_ptr0), .wr_ptr1(wr_ptr1)
  );

  // channel 0, APB only
  fifo_ctrl u_fifo_ch0
  (
    .clk(clk), .reset(reset), .push(push0), .pop(pop0),
    .wr_ptr(wr_ptr0), .rd_ptr(rd_ptr0), .full(full0), .empty(empty0), .count(count0)
  );

  // channel 1, APB and stream
  fifo_ctrl u_fifo_ch1
  (
    .clk(clk), .reset(reset), .push(push1), .pop(pop1),
    .wr_ptr(wr_ptr1), .rd_ptr(rd_ptr1), .full(full1), .empty(empty1), .count(count1)
  );

  sync_dual_port_ram u_ram
  (
    .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(ram_raddr), .rdata(ram_rdata)
  );

endmodule

//--- hw/fifo_ctrl.sv
// pointer and flag keeper for one channel of the buffer
// push and pop are trusted, the callers guard against full and empty
`timescale 1ns/1ps

module fifo_ctrl
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push,    // byte written at wr_ptr this cycle
  input  logic                    pop,     // byte taken from rd_ptr this cycle
  output fifo_buffer_pkg::ptr_t   wr_ptr,
  output fifo_buffer_pkg::ptr_t   rd_ptr,
  output logic                    full,
  output logic                    empty,
  output fifo_buffer_pkg::count_t count
);

  import fifo_buffer_pkg::*;

  ptr_t wr_next;  // pointer values after one step
  ptr_t rd_next;

  assign wr_next = wr_ptr + 1'b1;  // wraps at 16
  assign rd_next = rd_ptr + 1'b1;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;  // starts empty
      count  <= '0;
    end
    else
    begin
      case ({push, pop})
        2'b10:  // push alone
        begin
          wr_ptr <= wr_next;
          empty  <= 1'b0;
          count  <= count + 1'b1;
          if (wr_next == rd_ptr)
          begin
            full <= 1'b1;  // write side caught up with read side
          end
        end
        2'b01:  // pop alone
        begin
          rd_ptr <= rd_next;
          full   <= 1'b0;
          count  <= count - 1'b1;
          if (rd_next == wr_ptr)
          begin
            empty <= 1'b1;  // read side caught up, nothing left
          end
        end
        2'b11:  // both move, level unchanged
        begin
          wr_ptr <= wr_next;
          rd_ptr <= rd_next;
        end
        default:
        begin
          // idle, hold everything
        end
      endcase
    end
  end

endmodule

//--- hw/ram_write_arbiter.sv
// round-robin owner of the ram write port, APB pushes against stream ingress
// the stream always targets channel 1 and is held off while that channel is full
`timescale 1ns/1ps

module ram_write_arbiter
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       apb_push_req,   // already checked against full
  input  logic                       apb_push_ch,
  input  fifo_buffer_pkg::data_t     apb_push_data,
  output logic                       apb_push_gnt,
  input  logic                       in_valid,
  input  fifo_buffer_pkg::data_t     in_data,
  output logic                       in_ready,
  input  logic                       full1,
  output logic                       ram_we,
  output fifo_buffer_pkg::ram_addr_t ram_waddr,
  output fifo_buffer_pkg::data_t     ram_wdata,
  output logic                       push0,
  output logic                       push1,
  input  fifo_buffer_pkg::ptr_t      wr_ptr0,
  input  fifo_buffer_pkg::ptr_t      wr_ptr1
);

  import fifo_buffer_pkg::*;

  logic stream_req;  // stream wants the port and channel 1 has room
  logic prio;        // 0 favours APB, 1 favours the stream
  logic apb_win;
  logic stream_win;
  logic win_ch;      // channel of this cycle's write
  ptr_t win_ptr;

  assign stream_req = in_valid & ~full1;

  // APB wins when alone or when it holds priority
  assign apb_win    = apb_push_req & (~stream_req | ~prio);
  assign stream_win = stream_req & ~apb_win;

  assign apb_push_gnt = apb_win;
  assign in_ready     = stream_win;  // the transfer happens when this is high

  // priority flips only on a real conflict
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      prio <= 1'b0;  // APB wins the first conflict
    end
    else if (apb_push_req && stream_req)
    begin
      prio <= ~prio;
    end
  end

  // write path for the winner
  assign win_ch    = apb_win ? apb_push_ch : 1'b1;  // stream always lands in channel 1
  assign win_ptr   = win_ch ? wr_ptr1 : wr_ptr0;
  assign ram_we    = apb_win | stream_win;
  assign ram_waddr = {win_ch, win_ptr};
  assign ram_wdata = apb_win ? apb_push_data : in_data;

  // matching pointer advance in the owning controller
  assign push0 = ram_we & ~win_ch;
  assign push1 = ram_we & win_ch;

endmodule

//--- hw/sync_dual_port_ram.sv
// block RAM shared by both channels, one write port and one registered read port
// the channel number is the top address bit, so each channel owns half of it
`timescale 1ns/1ps

module sync_dual_port_ram
(
  input  logic                       clk,
  input  logic                       we,
  input  fifo_buffer_pkg::ram_addr_t waddr,
  input  fifo_buffer_pkg::data_t     wdata,
  input  fifo_buffer_pkg::ram_addr_t raddr,
  output fifo_buffer_pkg::data_t     rdata
);

  import fifo_buffer_pkg::*;

  data_t mem [0:(2**RAM_ADDR_W)-1];  // 32 bytes, no reset

  // write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // read port is registered, a same-address write shows the old byte
  always_ff @(posedge clk)
  begin
    rdata <= mem[raddr];
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the buffer testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fifo_buffer -Mdir obj_dir -f compile.f

./obj_dir/Vtb_fifo_buffer > sim.log 2>&1
cat sim.log

# a failing run still ends normally, so the result comes from the log
grep -q "^TB PASSED$" sim.log

//--- sim/tb_apb_tasks.svh
// APB host and byte stream source for the buffer testbench
// included in the testbench module body, inputs change 2 ns after the rising edge

// one APB transfer, setup then access, held through wait states
task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata);
  @(posedge clk);
  #2;
  psel    = 1'b1;  // setup phase
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(posedge clk);
  #2;
  penable = 1'b1;  // access phase
  do
  begin
    @(negedge clk);  // pready settled mid cycle
  end
  while (!pready);
  @(posedge clk);  // transfer ends at this edge
  #2;
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

// upper pwdata bits are random too, only the low byte is stored
task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
  apb_transfer(1'b1, addr, wdata);
endtask

task automatic apb_read(input apb_addr_t addr);
  apb_transfer(1'b0, addr, '0);  // result checked by the monitor
endtask

// n random bytes into channel 1, back to back unless held off
task automatic stream_send(input int n);
  @(posedge clk);
  #2;
  for (int i = 0; i < n; i++)
  begin
    in_valid = 1'b1;
    in_data  = data_t'($urandom);
    do
    begin
      @(negedge clk);
    end
    while (!in_ready);  // channel 1 full or APB won the port
    @(posedge clk);
    #2;
  end
  in_valid = 1'b0;
endtask

//--- sim/tb_fifo_buffer.sv
// testbench for the two-channel APB byte buffer with stream ingress into channel 1
// one model queue per channel, every completed transfer is checked by a negedge monitor
`timescale 1ns/1ps

module tb_fifo_buffer;

  import fifo_buffer_pkg::*;

  localparam int DEPTH      = 2**PTR_W;      // entries per channel
  localparam int MAX_CYCLES = 4000;          // ~130 transfers of up to 6 cycles, 5x margin
  localparam int SEED       = 32'h610b_3448;

  logic      clk;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      in_valid;
  data_t     in_data;
  logic      in_ready;

  data_t q0[$];          // reference model, channel 0
  data_t q1[$];          // channel 1, APB and stream bytes in arrival order
  string test_name;
  int    errors;
  int    checks;
  int    stall_cycles;   // stream held off while channel 1 is full
  int    cycle_count;

  fifo_buffer_top u_fifo_buffer_top
  (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready)
  );

  `include "tb_apb_tasks.svh"

  // status word the register map promises for the given fill levels
  function automatic apb_data_t expected_status(input int n0, input int n1);
    apb_data_t word;
    word                         = '0;
    word[ST_EMPTY0]              = (n0 == 0);
    word[ST_FULL0]               = (n0 == DEPTH);
    word[ST_EMPTY1]              = (n1 == 0);
    word[ST_FULL1]               = (n1 == DEPTH);
    word[ST_COUNT0 +: PTR_W + 1] = count_t'(n0);
    word[ST_COUNT1 +: PTR_W + 1] = count_t'(n1);
    return word;
  endfunction

  function automatic int queue_size(input logic ch);
    return ch ? q1.size() : q0.size();
  endfunction

  function automatic data_t queue_pop(input logic ch);
    return ch ? q1.pop_front() : q0.pop_front();
  endfunction

  task automatic check_value(input string what, input apb_data_t expected,
                             input apb_data_t actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("[ERROR] %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  // one completed APB transfer against the model
  task automatic check_transfer();
    logic ch;
    logic exp_err;
    ch = (paddr == REG_DATA1);
    if ((paddr == REG_DATA0 || paddr == REG_DATA1) && pwrite)
    begin
      exp_err = (queue_size(ch) == DEPTH);  // overflow drops the byte
      check_value("write pslverr", apb_data_t'(exp_err), apb_data_t'(pslverr));
      if (!pslverr)
      begin
        if (ch)
          q1.push_back(pwdata[DATA_W-1:0]);
        else
          q0.push_back(pwdata[DATA_W-1:0]);
      end
    end
    else if (paddr == REG_DATA0 || paddr == REG_DATA1)
    begin
      exp_err = (queue_size(ch) == 0);  // underflow
      check_value("read pslverr", apb_data_t'(exp_err), apb_data_t'(pslverr));
      if (exp_err)
        check_value("underflow prdata", '0, prdata);
      else
        check_value("read data", apb_data_t'(queue_pop(ch)), prdata);
    end
    else if (paddr == REG_STATUS && !pwrite)
      check_value("status", expected_status(q0.size(), q1.size()), prdata);
    else
      check_value("decode pslverr", apb_data_t'(1'b1), apb_data_t'(pslverr));
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // outputs settle by mid cycle, model updates land before the edge that moves the DUT
  always @(negedge clk)
  begin
    if (psel && penable && pready)
      check_transfer();
    if (in_valid && q1.size() == DEPTH)
    begin
      if (!in_ready)
      begin
        stall_cycles++;  // back-pressure seen at the port
      end
      check_value("in_ready with channel 1 full", '0, apb_data_t'(in_ready));
    end
    if (in_valid && in_ready)
      q1.push_back(in_data);  // stream byte taken at the next edge
  end

  initial
  begin
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(SEED));
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    test_name = "order";  // interleaved channels read back in write order
    for (int i = 0; i < 6; i++)
    begin
      apb_write(REG_DATA0, $urandom);
      apb_write(REG_DATA1, $urandom);
    end
    apb_read(REG_STATUS);
    for (int i = 0; i < 6; i++)
    begin
      apb_read(REG_DATA1);
      apb_read(REG_DATA0);
    end
    apb_read(REG_STATUS);

    test_name = "overflow";
    repeat (DEPTH) apb_write(REG_DATA0, $urandom);
    apb_read(REG_STATUS);          // full0 set
    apb_write(REG_DATA0, $urandom);  // 17th byte, pslverr
    repeat (DEPTH) apb_read(REG_DATA0);
    apb_read(REG_STATUS);

    test_name = "underflow";
    apb_read(REG_DATA0);
    apb_read(REG_DATA1);
    apb_read(8'h0C);               // unmapped
    apb_write(REG_STATUS, $urandom);  // read only
    apb_read(REG_STATUS);

    test_name = "shared port";
    fork
      stream_send(DEPTH + 4);      // 4 more than fit, stream must stall
      begin
        repeat (8) apb_write(REG_DATA0, $urandom);
        while (q1.size() < DEPTH)
          @(posedge clk);
        repeat (6) @(posedge clk);  // hold with channel 1 full
        apb_read(REG_STATUS);
        check_value("stream stalled", apb_data_t'(1'b1), apb_data_t'(stall_cycles > 0));
        repeat (8) apb_read(REG_DATA0);
        repeat (DEPTH + 4) apb_read(REG_DATA1);
      end
    join
    apb_read(REG_STATUS);

    test_name = "push and pop";  // stream pushes while APB pops channel 1
    fork
      stream_send(24);
      repeat (20) apb_read(REG_DATA1);
    join
    apb_read(REG_STATUS);
    while (q1.size() > 0)
      apb_read(REG_DATA1);
    apb_read(REG_STATUS);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
